//--- Makefile
# Verilator build and run of the RV32I front-end testbench, run from the project root

SIM := obj_dir/rv_frontend_sim

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): all.f *.sv *.svh
	verilator --binary --timing --assert -j 0 -f all.f --top-module rv_frontend_tb \
		-Mdir obj_dir -o rv_frontend_sim

# The simulator exits non-zero on any $fatal or failed assertion
run: compile
	./$(SIM)

clean:
	rm -rf obj_dir

//--- all.f
+incdir+.
rv_frontend_pkg.sv
imem_rom.sv
inst_fetch.sv
fetch_queue.sv
inst_decode.sv
rv_frontend.sv
tb_clkgen.sv
rv_frontend_chk.sv
rv_frontend_tb.sv

//--- fetch_queue.sv
// Flushable circular FIFO of fetch packets between the fetch and decode stages
`default_nettype none
`timescale 1ns/1ps
`include "rv_frontend_params.svh"

module fetch_queue
	import rv_frontend_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          flush,          // Drop all entries, has priority
	input  logic          push,           // Write din at this edge
	input  fetch_packet_t din,
	input  logic          pop,            // Remove head at this edge
	output fetch_packet_t head,           // Oldest entry, meaningful when not_empty
	output logic          not_empty,
	output logic          almost_full     // Stall level for the producer
);

	localparam int DEPTH = `FQ_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	fetch_packet_t    mem [0:DEPTH-1];    // Entry storage, contents need no reset
	logic [PTR_W-1:0] rd_ptr;             // Index of the head entry
	logic [PTR_W-1:0] wr_ptr;             // Index of the next free entry
	logic [CNT_W-1:0] count;              // Entries currently held
	logic             full;
	logic             do_push;
	logic             do_pop;

	assign full      = (count == CNT_W'(DEPTH));
	assign not_empty = (count != '0);

	// Two slots of headroom cover the word already in flight in the ROM
	assign almost_full = (count >= CNT_W'(DEPTH - 2));

	// A push into a full queue is only taken if the head leaves at the same edge
	assign do_push = push & (~full | pop);
	assign do_pop  = pop & not_empty;

	assign head = mem[rd_ptr];

	// Payload write, no reset on the storage itself
	always_ff @(posedge clk) begin
		if (do_push && !flush) begin
			mem[wr_ptr] <= din;
		end
	end

	// Pointers and count
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or neither leave the level unchanged
			endcase
		end
	end

endmodule

`default_nettype wire

//--- imem.hex
// One 32-bit RV32I instruction word per line in hex, word index 0 to 31 from the top
00500093
123450b7
00001117
008000ef
000080e7
fe209ee3
0040a183
fe312e23
002081b3
40208233
00000073
00100073
ffffffff
00000000
fff14293
800002b7
fff00313
80000397
fedff06f
7ff00413
80040493
0000d463
fe0a8ae3
00452503
00b52023
c0002573
0ff0000f
0062f5b3
00361613
4036d693
80068767
0000006b

//--- imem_rom.sv
// Synchronous instruction ROM filled from imem.hex at start; one registered word per cycle
`default_nettype none
`timescale 1ns/1ps
`include "rv_frontend_params.svh"

module imem_rom (
	input  logic        clk,
	input  logic [4:0]  addr,             // Word index, taken from pc[6:2]
	output logic [31:0] rdata             // Word at the index sampled at the last edge
);

	logic [31:0] mem [0:`ROM_WORDS-1];    // Program image, never written by the design

	// The image is one hex word per line
	initial begin
		$readmemh("imem.hex", mem);
	end

	// Address sampled at the edge, word valid right after it
	always_ff @(posedge clk) begin
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

//--- inst_decode.sv
// RV32I field and immediate decoder; pops the fetch queue and registers one record per pop
`default_nettype none
`timescale 1ns/1ps

module inst_decode
	import rv_frontend_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          redirect,       // Later stages restart the stream
	input  logic          hold,           // Back-pressure level from later stages
	input  fetch_packet_t head,           // Oldest queued packet
	input  logic          not_empty,
	output logic          pop,            // Take head at this edge
	output decoded_inst_t dec,            // Registered record
	output logic          dec_valid       // Strobe, one per decoded instruction
);

	logic [31:0]   ins;                   // Shorthand for the head word
	inst_class_t   cls;                   // Class of the head word
	logic [31:0]   imm;                   // Immediate in the format of cls
	decoded_inst_t dec_next;              // Record for the head word

	assign ins = head.instr;

	// Nothing leaves the queue while held or when the stream is being replaced
	assign pop = not_empty & ~hold & ~redirect;

	// Class from the major opcode only
	always_comb begin
		case (ins[6:0])
			OPC_LUI:    cls = cls_lui;
			OPC_AUIPC:  cls = cls_auipc;
			OPC_JAL:    cls = cls_jal;
			OPC_JALR:   cls = cls_jalr;
			OPC_BRANCH: cls = cls_branch;
			OPC_LOAD:   cls = cls_load;
			OPC_STORE:  cls = cls_store;
			OPC_OP_IMM: cls = cls_alu_imm;
			OPC_OP:     cls = cls_alu_reg;
			OPC_SYSTEM: cls = cls_system;
			default:    cls = cls_illegal;
		endcase
	end

	// Immediate formats, all sign-extended from bit 31
	always_comb begin
		case (cls)
			cls_jalr, cls_load, cls_alu_imm, cls_system:
				imm = {{20{ins[31]}}, ins[31:20]};                           // I
			cls_store:
				imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};                // S
			cls_branch:
				imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}; // B
			cls_lui, cls_auipc:
				imm = {ins[31:12], 12'b0};                                   // U
			cls_jal:
				imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			default:
				imm = 32'b0;              // R-type and illegal carry no immediate
		endcase
	end

	// Register and function fields sit at fixed positions in every format
	always_comb begin
		dec_next.pc     = head.pc;
		dec_next.cls    = cls;
		dec_next.rd     = ins[11:7];
		dec_next.rs1    = ins[19:15];
		dec_next.rs2    = ins[24:20];
		dec_next.funct3 = ins[14:12];
		dec_next.funct7 = ins[31:25];
		dec_next.imm    = imm;
	end

	// Record is only loaded on a pop, so it stays stable between strobes
	always_ff @(posedge clk) begin
		if (pop) begin
			dec <= dec_next;
		end
	end

	// Valid follows the pop by one cycle; pop is already low on redirect and hold
	always_ff @(posedge clk) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= pop;
		end
	end

endmodule

`default_nettype wire

//--- inst_fetch.sv
// Program counter and fetch control; issues one ROM read per cycle and produces fetch packets
`default_nettype none
`timescale 1ns/1ps
`include "rv_frontend_params.svh"

module inst_fetch
	import rv_frontend_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          stall,          // Queue near full, hold the pc
	input  logic          redirect,       // One-cycle strobe from later stages
	input  logic [31:0]   redirect_pc,    // New target, valid with redirect
	output fetch_packet_t fetch_pkt,      // Word returning from the ROM with its pc
	output logic          fetch_valid     // Packet is good to push this cycle
);

	logic [31:0] pc;                      // Address sampled by the ROM at the last edge
	logic [31:0] next_pc;                 // Address presented to the ROM this cycle
	logic [31:0] pc_plus4;                // Sequential successor of pc
	logic        issued;                  // An address was issued at the last edge
	logic [31:0] rom_word;                // ROM output, pairs with pc

	assign pc_plus4 = pc + 32'd4;

	// Redirect wins, then the stall holds, otherwise step by one word
	always_comb begin
		if (redirect) begin
			next_pc = redirect_pc;
		end else if (stall) begin
			next_pc = pc;                 // Re-read the same word, it is not marked issued
		end else begin
			next_pc = pc_plus4;
		end
	end

	// The pc register tracks what the ROM is reading, so it lines up with rdata
	always_ff @(posedge clk) begin
		if (reset) begin
			pc     <= `RESET_PC - 32'd4;  // So the first issued address is the reset vector
			issued <= 1'b0;
		end else begin
			pc     <= next_pc;
			issued <= redirect | ~stall;  // The queue empties on redirect, so the target goes out
		end
	end

	imem_rom i_imem_rom (
		.clk   (clk),
		.addr  (next_pc[6:2]),            // Index wraps every 128 bytes
		.rdata (rom_word)
	);

	assign fetch_pkt.pc    = pc;
	assign fetch_pkt.instr = rom_word;

	// A word coming back while a redirect is taken belongs to the old stream
	assign fetch_valid = issued & ~redirect;

endmodule

`default_nettype wire

//--- rv_frontend.sv
// Top of the RV32I front end; chains fetch, fetch queue and decode for the testbench or a core
`default_nettype none
`timescale 1ns/1ps

module rv_frontend
	import rv_frontend_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          redirect,       // One-cycle restart strobe
	input  logic [31:0]   redirect_pc,    // Restart target
	input  logic          hold,           // Back-pressure from the rest of the pipeline
	output decoded_inst_t dec,            // Decoded record
	output logic          dec_valid       // Record strobe
);

	fetch_packet_t fetch_pkt;             // Producer output
	logic          fetch_valid;
	logic          almost_full;           // Queue level used as the fetch stall
	fetch_packet_t head;                  // Consumer input
	logic          not_empty;
	logic          pop;

	inst_fetch i_inst_fetch (
		.clk         (clk),
		.reset       (reset),
		.stall       (almost_full),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.fetch_pkt   (fetch_pkt),
		.fetch_valid (fetch_valid)
	);

	fetch_queue i_fetch_queue (
		.clk         (clk),
		.reset       (reset),
		.flush       (redirect),          // Old-stream packets are dropped on restart
		.push        (fetch_valid),
		.din         (fetch_pkt),
		.pop         (pop),
		.head        (head),
		.not_empty   (not_empty),
		.almost_full (almost_full)
	);

	inst_decode i_inst_decode (
		.clk       (clk),
		.reset     (reset),
		.redirect  (redirect),
		.hold      (hold),
		.head      (head),
		.not_empty (not_empty),
		.pop       (pop),
		.dec       (dec),
		.dec_valid (dec_valid)
	);

endmodule

`default_nettype wire

//--- rv_frontend_chk.sv
// Concurrent assertions on the fetch queue and the decoded output, bound into rv_frontend
`default_nettype none
`timescale 1ns/1ps
`include "rv_frontend_params.svh"

module rv_frontend_chk (
	input logic       clk,
	input logic       reset,
	input logic       redirect,
	input logic       hold,
	input logic       dec_valid,
	input logic [2:0] q_count,            // Queue fill level
	input logic       q_push              // Push request into the queue
);

	logic q_full;                         // Queue holds FQ_DEPTH entries

	assign q_full = (q_count == 3'(`FQ_DEPTH));

	// The level can never pass the number of slots
	count_in_range: assert property (@(posedge clk) disable iff (reset)
		q_count <= 3'(`FQ_DEPTH))
		else $error("fetch queue count above its depth");

	// The stall headroom must keep the producer away from a full queue
	no_push_full: assert property (@(posedge clk) disable iff (reset)
		!(q_push && q_full))
		else $error("push into a full fetch queue");

	// A restart kills the record that would have followed
	quiet_after_redirect: assert property (@(posedge clk) disable iff (reset)
		redirect |=> !dec_valid)
		else $error("dec_valid high in the cycle after a redirect");

	// Back-pressure stops the output one cycle later
	quiet_after_hold: assert property (@(posedge clk) disable iff (reset)
		hold |=> !dec_valid)
		else $error("dec_valid high after hold was sampled high");

endmodule

bind rv_frontend rv_frontend_chk i_rv_frontend_chk (
	.clk       (clk),
	.reset     (reset),
	.redirect  (redirect),
	.hold      (hold),
	.dec_valid (dec_valid),
	.q_count   (i_fetch_queue.count),
	.q_push    (i_fetch_queue.push)
);

`default_nettype wire

//--- rv_frontend_params.svh
// Shared sizing constants for the RV32I front end, included by the RTL and the testbench
`ifndef RV_FRONTEND_PARAMS_SVH
`define RV_FRONTEND_PARAMS_SVH

// First pc fetched once reset is released
`define RESET_PC 32'h0000_0100

// Instruction ROM size in 32-bit words
// The word index is pc[6:2], so the image repeats every 128 bytes
`define ROM_WORDS 32

// Number of entries in the fetch queue
`define FQ_DEPTH 4

`endif

//--- rv_frontend_pkg.sv
// Types shared by the fetch, queue and decode stages and by the testbench; import where needed
`default_nettype none

package rv_frontend_pkg;

	// One fetched word together with the address it came from
	typedef struct packed {
		logic [31:0] pc;                  // Byte address of the word
		logic [31:0] instr;               // Raw instruction bits from the ROM
	} fetch_packet_t;

	// Coarse instruction class, picked from the major opcode alone
	typedef enum logic [3:0] {
		cls_lui     = 4'd0,               // Load upper immediate
		cls_auipc   = 4'd1,               // Add upper immediate to pc
		cls_jal     = 4'd2,               // Direct jump and link
		cls_jalr    = 4'd3,               // Register indirect jump and link
		cls_branch  = 4'd4,               // Conditional branches
		cls_load    = 4'd5,               // All load widths
		cls_store   = 4'd6,               // All store widths
		cls_alu_imm = 4'd7,               // Register-immediate ALU ops
		cls_alu_reg = 4'd8,               // Register-register ALU ops
		cls_system  = 4'd9,               // ecall, ebreak and CSR space
		cls_illegal = 4'd10               // Anything the decoder does not know
	} inst_class_t;

	// One decoded instruction as presented on the front-end output
	typedef struct packed {
		logic [31:0] pc;                  // Address of the instruction
		inst_class_t cls;                 // Class from the opcode
		logic [4:0]  rd;                  // Destination register, bits 11:7
		logic [4:0]  rs1;                 // First source register, bits 19:15
		logic [4:0]  rs2;                 // Second source register, bits 24:20
		logic [2:0]  funct3;              // Minor opcode, bits 14:12
		logic [6:0]  funct7;              // Bits 31:25, also the upper R-type opcode
		logic [31:0] imm;                 // Sign-extended immediate for the class format
	} decoded_inst_t;

	// Major opcodes of the base integer set
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

endpackage

`default_nettype wire

//--- rv_frontend_tb.sv
// Testbench top for the RV32I front end; applies the stimulus table and checks every record
`default_nettype none
`timescale 1ns/1ps
`include "rv_frontend_params.svh"

module rv_frontend_tb
	import rv_frontend_pkg::*;
;

	typedef struct packed {
		int          cycles;              // Cycles the row is applied
		logic        hold;
		logic        redirect;            // Rows with a redirect last one cycle
		logic [31:0] target;
	} row_t;

	localparam int NROWS = 15;

	// Reset stream, hold, two redirects, redirect in hold and after release, final hold
	row_t rows [0:NROWS-1] = '{
		'{20, 1'b0, 1'b0, 32'h0000_0000},
		'{10, 1'b1, 1'b0, 32'h0000_0000},
		'{8,  1'b0, 1'b0, 32'h0000_0000},
		'{1,  1'b0, 1'b1, 32'h0000_0140},
		'{12, 1'b0, 1'b0, 32'h0000_0000},
		'{1,  1'b0, 1'b1, 32'h0000_0FF8},
		'{12, 1'b0, 1'b0, 32'h0000_0000},
		'{4,  1'b1, 1'b0, 32'h0000_0000},
		'{1,  1'b1, 1'b1, 32'h0000_0120},
		'{3,  1'b1, 1'b0, 32'h0000_0000},
		'{6,  1'b0, 1'b0, 32'h0000_0000},
		'{4,  1'b1, 1'b0, 32'h0000_0000},
		'{1,  1'b0, 1'b1, 32'h0000_0180},
		'{10, 1'b0, 1'b0, 32'h0000_0000},
		'{6,  1'b1, 1'b0, 32'h0000_0000}
	};

	logic          clk;
	logic          reset;
	logic          hold;
	logic          redirect;
	logic [31:0]   redirect_pc;
	decoded_inst_t dec;
	logic          dec_valid;

	logic [31:0]   rom [0:`ROM_WORDS-1];  // Own copy of the program image
	logic [31:0]   exp_pc;                // Next pc the stream rule predicts
	int            rcv_count;             // Records seen on the output
	int            exp_count;             // Records the table implies
	int            idle_cycles;           // Consecutive cycles without dec_valid
	int            m_level;               // Expected queue level
	logic          m_issued;              // A fetch address went out at the last edge
	logic          m_pop;                 // Expected pop at the coming edge
	logic          m_push;                // Expected push at the coming edge

	tb_clkgen #(.PERIOD_NS(40), .RESET_CYCLES(3)) i_tb_clkgen (
		.clk   (clk),
		.reset (reset)
	);

	rv_frontend i_rv_frontend (
		.clk         (clk),
		.reset       (reset),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.hold        (hold),
		.dec         (dec),
		.dec_valid   (dec_valid)
	);

	task automatic stop_on_error();
		$display("Verification failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("** Error @%0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
		stop_on_error();
	endtask

	// Field-by-field compare of one decoded record
	task automatic check_decoded(input decoded_inst_t got, input decoded_inst_t exp);
		if (got.pc !== exp.pc) report_value("dec.pc", got.pc, exp.pc);
		if (got.cls !== exp.cls) report_value("dec.cls", 32'(got.cls), 32'(exp.cls));
		if (got.rd !== exp.rd) report_value("dec.rd", 32'(got.rd), 32'(exp.rd));
		if (got.rs1 !== exp.rs1) report_value("dec.rs1", 32'(got.rs1), 32'(exp.rs1));
		if (got.rs2 !== exp.rs2) report_value("dec.rs2", 32'(got.rs2), 32'(exp.rs2));
		if (got.funct3 !== exp.funct3) report_value("dec.funct3", 32'(got.funct3), 32'(exp.funct3));
		if (got.funct7 !== exp.funct7) report_value("dec.funct7", 32'(got.funct7), 32'(exp.funct7));
		if (got.imm !== exp.imm) report_value("dec.imm", got.imm, exp.imm);
	endtask

	task automatic check_count(input int got, input int exp);
		if (got != exp) report_value("record count", 32'(got), 32'(exp));
	endtask

	// Reference decode of the word at pc, using the ISA formats directly
	function automatic decoded_inst_t ref_decode(input logic [31:0] pc);
		logic [31:0]   w;
		decoded_inst_t r;
		w        = rom[pc[6:2]];          // Image repeats every 128 bytes
		r.pc     = pc;
		r.rd     = w[11:7];
		r.rs1    = w[19:15];
		r.rs2    = w[24:20];
		r.funct3 = w[14:12];
		r.funct7 = w[31:25];
		case (w[6:0])
			7'h37: r.cls = cls_lui;
			7'h17: r.cls = cls_auipc;
			7'h6f: r.cls = cls_jal;
			7'h67: r.cls = cls_jalr;
			7'h63: r.cls = cls_branch;
			7'h03: r.cls = cls_load;
			7'h23: r.cls = cls_store;
			7'h13: r.cls = cls_alu_imm;
			7'h33: r.cls = cls_alu_reg;
			7'h73: r.cls = cls_system;
			default: r.cls = cls_illegal;
		endcase
		if (r.cls == cls_lui || r.cls == cls_auipc) r.imm = {w[31:12], 12'h000};
		else if (r.cls == cls_jal) r.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		else if (r.cls == cls_branch) r.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		else if (r.cls == cls_store) r.imm = {{21{w[31]}}, w[30:25], w[11:7]};
		else if (r.cls == cls_alu_reg || r.cls == cls_illegal) r.imm = 32'h0;
		else r.imm = {{21{w[31]}}, w[30:20]};  // I format for the rest
		return r;
	endfunction

	// Outputs and inputs are both settled at the falling edge
	always @(negedge clk) begin
		if (reset) begin
			exp_pc   = `RESET_PC;
			m_level  = 0;
			m_issued = 1'b0;
		end else begin
			if (dec_valid === 1'b1) begin
				check_decoded(dec, ref_decode(exp_pc));
				exp_pc      = exp_pc + 32'd4;
				rcv_count   = rcv_count + 1;
				idle_cycles = 0;
			end else begin
				idle_cycles = idle_cycles + 1;
			end
			if (redirect) exp_pc = redirect_pc;  // Records after this edge start at the target
			// Expected pop and push at the coming edge, from the queue level and the fetch rules
			m_pop  = (m_level != 0) && !hold && !redirect;
			m_push = m_issued && !redirect;      // A word returning on a redirect is dropped
			if (m_pop) exp_count = exp_count + 1;
			m_issued = redirect || (m_level < `FQ_DEPTH - 2);  // Stall uses the level before the edge
			if (redirect) begin
				m_level = 0;
			end else begin
				m_level = m_level + int'(m_push) - int'(m_pop);
			end
		end
	end

	// Hard limit for the whole run
	initial begin
		repeat (4000) @(posedge clk);
		$display("Timeout: the simulation ran past its cycle limit");
		stop_on_error();
	end

	initial begin
		int r;
		int c;
		int t;
		hold        = 1'b0;
		redirect    = 1'b0;
		redirect_pc = 32'h0;
		rcv_count   = 0;
		exp_count   = 0;
		idle_cycles = 0;
		$readmemh("imem.hex", rom);
		for (t = 0; t < 20 && reset !== 1'b0; t++) @(posedge clk);
		if (reset !== 1'b0) begin
			$display("Timeout: reset was never released");
			stop_on_error();
		end
		for (r = 0; r < NROWS; r++) begin
			for (c = 0; c < rows[r].cycles; c++) begin
				@(posedge clk);
				hold        <= rows[r].hold;
				redirect    <= rows[r].redirect;
				redirect_pc <= rows[r].target;
			end
		end
		// Final drain, the output must go quiet while hold stays high
		for (t = 0; t < 50 && idle_cycles < 4; t++) @(posedge clk);
		if (idle_cycles < 4) begin
			$display("Timeout: the output did not go quiet during the final drain");
			stop_on_error();
		end
		check_count(rcv_count, exp_count);
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_clkgen.sv
// Testbench clock and synchronous reset source; instantiate once in the testbench top
`default_nettype none
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD_NS    = 40,      // Full clock period
	parameter int RESET_CYCLES = 3        // Rising edges with reset high
) (
	output logic clk,
	output logic reset
);

	// Free-running clock, low for the first half period
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Reset drops at a rising edge, like any other synchronous input
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire
